// File: shift_pkg.sv
package shift_pkg;

  localparam int WORD_WIDTH      = 32;
  localparam int HWORD_WIDTH     = 16;
  localparam int XLEN            = 32;
  localparam int SHAMT_WIDTH     = 5;
  localparam int ROB_DEPTH_WIDTH = 3;
  // bit 0 picks the destination half of a narrowing op
  localparam int UOP_INDEX_WIDTH = 3;

  typedef enum logic [5:0] {
    vsll    = 6'b100101,
    vsrl    = 6'b101000,
    vsra    = 6'b101001,
    vssrl   = 6'b101010,
    vssra   = 6'b101011,
    vnsrl   = 6'b101100,
    vnsra   = 6'b101101,
    vnclipu = 6'b101110,
    vnclip  = 6'b101111
  } funct6_e;

  typedef enum logic [2:0] {
    opivv = 3'b000,
    opivi = 3'b011,
    opivx = 3'b100
  } funct3_e;

  // fixed-point rounding modes
  typedef enum logic [1:0] {
    rnu = 2'd0,
    rne = 2'd1,
    rdn = 2'd2,
    rod = 2'd3
  } vxrm_e;

  // srl and sra also set unsigned or signed handling in the lane
  typedef enum logic [1:0] {
    shift_sll = 2'd0,
    shift_srl = 2'd1,
    shift_sra = 2'd2
  } shift_e;

endpackage

// File: shift_decode.sv
`timescale 1ns/10ps

module shift_decode
  import shift_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              uop_valid,
  input  funct6_e                                           uop_funct6,
  input  funct3_e                                           uop_funct3,
  input  vxrm_e                                             vxrm,
  input  logic [VLEN-1:0]                                   vs1_data,
  input  logic [VLEN-1:0]                                   vs2_data,
  input  logic [XLEN-1:0]                                   rs1_data,
  input  logic [UOP_INDEX_WIDTH-1:0]                        uop_index,
  input  logic [ROB_DEPTH_WIDTH-1:0]                        rob_entry,
  output logic                                              stage_valid,
  output logic [ROB_DEPTH_WIDTH-1:0]                        stage_rob_entry,
  output logic [VLEN/WORD_WIDTH-1:0][WORD_WIDTH-1:0]        lane_operand,
  output logic [VLEN/WORD_WIDTH-1:0][SHAMT_WIDTH-1:0]       lane_shamt,
  output shift_e                                            shift_kind,
  output logic                                              round_en,
  output logic                                              clip_en,
  output vxrm_e                                             stage_vxrm,
  output logic                                              narrow,
  output logic                                              upper_half
);

  localparam int LANES = VLEN / WORD_WIDTH;

  logic                               fn_known;
  logic                               fmt_known;
  logic                               accept;
  shift_e                             kind_d;
  logic                               round_d;
  logic                               clip_d;
  logic                               narrow_d;
  logic [LANES-1:0][SHAMT_WIDTH-1:0]  shamt_d;

  always_comb begin
    fn_known = 1'b1;
    kind_d   = shift_sll;
    round_d  = 1'b0;
    clip_d   = 1'b0;
    narrow_d = 1'b0;
    case (uop_funct6)
      vsll:  kind_d = shift_sll;
      vsrl:  kind_d = shift_srl;
      vsra:  kind_d = shift_sra;
      vssrl: begin
        kind_d  = shift_srl;
        round_d = 1'b1;
      end
      vssra: begin
        kind_d  = shift_sra;
        round_d = 1'b1;
      end
      vnsrl: begin
        kind_d   = shift_srl;
        narrow_d = 1'b1;
      end
      vnsra: begin
        kind_d   = shift_sra;
        narrow_d = 1'b1;
      end
      vnclipu: begin
        kind_d   = shift_srl;
        round_d  = 1'b1;
        clip_d   = 1'b1;
        narrow_d = 1'b1;
      end
      vnclip: begin
        kind_d   = shift_sra;
        round_d  = 1'b1;
        clip_d   = 1'b1;
        narrow_d = 1'b1;
      end
      default: fn_known = 1'b0;
    endcase
  end

  assign fmt_known = (uop_funct3 == opivv) || (uop_funct3 == opivi) || (uop_funct3 == opivx);
  assign accept    = uop_valid && fn_known && fmt_known;

  // narrowing vv ops read halfword i of the half that matches the destination
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (uop_funct3 != opivv) begin
        shamt_d[i] = rs1_data[SHAMT_WIDTH-1:0];
      end else if (narrow_d) begin
        shamt_d[i] = vs1_data[(uop_index[0] ? VLEN/2 : 0) + i*HWORD_WIDTH +: SHAMT_WIDTH];
      end else begin
        shamt_d[i] = vs1_data[i*WORD_WIDTH +: SHAMT_WIDTH];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stage_rob_entry <= rob_entry;
      lane_operand    <= vs2_data;
      lane_shamt      <= shamt_d;
      shift_kind      <= kind_d;
      round_en        <= round_d;
      clip_en         <= clip_d;
      stage_vxrm      <= vxrm;
      narrow          <= narrow_d;
      upper_half      <= uop_index[0];
    end
  end

endmodule

// File: shift_lane.sv
`timescale 1ns/10ps

module shift_lane
  import shift_pkg::*;
(
  input  logic [WORD_WIDTH-1:0]  operand,
  input  logic [SHAMT_WIDTH-1:0] shamt,
  input  shift_e                 shift_kind,
  input  logic                   round_en,
  input  logic                   clip_en,
  input  vxrm_e                  vxrm,
  output logic [WORD_WIDTH-1:0]  lane_result,
  output logic                   sat
);

  logic                          is_sra;
  logic signed [2*WORD_WIDTH:0]  ext_src;
  logic [2*WORD_WIDTH:0]         shifted;
  logic [WORD_WIDTH-1:0]         sll_result;
  logic [WORD_WIDTH-1:0]         product;
  logic [WORD_WIDTH-1:0]         round_bits;
  logic                          round_inc;
  logic [WORD_WIDTH:0]           rounded;
  logic                          over_hi;
  logic                          over_lo;
  logic [HWORD_WIDTH-1:0]        clipped;

  assign is_sra = (shift_kind == shift_sra);

  // operand sits above a zero word so the dropped bits land in the low half
  assign ext_src    = {is_sra & operand[WORD_WIDTH-1], operand, {WORD_WIDTH{1'b0}}};
  assign shifted    = ext_src >>> shamt;
  assign sll_result = operand << shamt;

  assign product    = shifted[2*WORD_WIDTH-1:WORD_WIDTH];
  assign round_bits = shifted[WORD_WIDTH-1:0];

  always_comb begin
    round_inc = 1'b0;
    if (round_en) begin
      case (vxrm)
        rnu: round_inc = round_bits[WORD_WIDTH-1];
        rne: begin
          round_inc = round_bits[WORD_WIDTH-1] &
                      ((|round_bits[WORD_WIDTH-2:0]) | product[0]);
        end
        rdn: round_inc = 1'b0;
        rod: round_inc = ~product[0] & (|round_bits);
        default: round_inc = 1'b0;
      endcase
    end
  end

  // one extra bit keeps the carry of the increment
  assign rounded = {is_sra & product[WORD_WIDTH-1], product} +
                   {{WORD_WIDTH{1'b0}}, round_inc};

  always_comb begin
    over_hi = 1'b0;
    over_lo = 1'b0;
    clipped = rounded[HWORD_WIDTH-1:0];
    if (is_sra) begin
      // in range only when bits 32 down to 15 all equal the sign
      if (!rounded[WORD_WIDTH] && (|rounded[WORD_WIDTH-1:HWORD_WIDTH-1])) begin
        over_hi = 1'b1;
      end
      if (rounded[WORD_WIDTH] && !(&rounded[WORD_WIDTH-1:HWORD_WIDTH-1])) begin
        over_lo = 1'b1;
      end
      if (over_hi) begin
        clipped = {1'b0, {(HWORD_WIDTH-1){1'b1}}};
      end else if (over_lo) begin
        clipped = {1'b1, {(HWORD_WIDTH-1){1'b0}}};
      end
    end else begin
      over_hi = |rounded[WORD_WIDTH:HWORD_WIDTH];
      if (over_hi) begin
        clipped = {HWORD_WIDTH{1'b1}};
      end
    end
  end

  // rounded equals product when rounding is off
  always_comb begin
    if (shift_kind == shift_sll) begin
      lane_result = sll_result;
    end else if (clip_en) begin
      lane_result = {{HWORD_WIDTH{1'b0}}, clipped};
    end else begin
      lane_result = rounded[WORD_WIDTH-1:0];
    end
  end

  assign sat = clip_en & (over_hi | over_lo);

endmodule

// File: shift_pack.sv
`timescale 1ns/10ps

module shift_pack
  import shift_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        stage_valid,
  input  logic [ROB_DEPTH_WIDTH-1:0]                  stage_rob_entry,
  input  logic [VLEN/WORD_WIDTH-1:0][WORD_WIDTH-1:0]  lane_result,
  input  logic [VLEN/WORD_WIDTH-1:0]                  lane_sat,
  input  logic                                        narrow,
  input  logic                                        upper_half,
  output logic                                        result_valid,
  output logic [ROB_DEPTH_WIDTH-1:0]                  result_rob_entry,
  output logic [VLEN-1:0]                             result_data,
  output logic                                        result_vxsat
);

  localparam int LANES = VLEN / WORD_WIDTH;

  logic [VLEN-1:0] packed_data;
  logic            packed_sat;

  // narrow results fill one half, the other half stays zero
  always_comb begin
    packed_data = '0;
    for (int i = 0; i < LANES; i++) begin
      if (narrow) begin
        packed_data[(upper_half ? VLEN/2 : 0) + i*HWORD_WIDTH +: HWORD_WIDTH] =
          lane_result[i][HWORD_WIDTH-1:0];
      end else begin
        packed_data[i*WORD_WIDTH +: WORD_WIDTH] = lane_result[i];
      end
    end
  end

  assign packed_sat = |lane_sat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result_vxsat <= 1'b0;
    end else begin
      result_valid <= stage_valid;
      result_vxsat <= stage_valid & packed_sat;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_valid) begin
      result_rob_entry <= stage_rob_entry;
      result_data      <= packed_data;
    end
  end

endmodule

// File: shift_unit.sv
`timescale 1ns/10ps

module shift_unit
  import shift_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        uop_valid,
  input  funct6_e                     uop_funct6,
  input  funct3_e                     uop_funct3,
  input  vxrm_e                       vxrm,
  input  logic [VLEN-1:0]             vs1_data,
  input  logic [VLEN-1:0]             vs2_data,
  input  logic [XLEN-1:0]             rs1_data,
  input  logic [UOP_INDEX_WIDTH-1:0]  uop_index,
  input  logic [ROB_DEPTH_WIDTH-1:0]  rob_entry,
  output logic                        result_valid,
  output logic [ROB_DEPTH_WIDTH-1:0]  result_rob_entry,
  output logic [VLEN-1:0]             result_data,
  output logic                        result_vxsat
);

  localparam int LANES = VLEN / WORD_WIDTH;

  logic                               stage_valid;
  logic [ROB_DEPTH_WIDTH-1:0]         stage_rob_entry;
  logic [LANES-1:0][WORD_WIDTH-1:0]   lane_operand;
  logic [LANES-1:0][SHAMT_WIDTH-1:0]  lane_shamt;
  shift_e                             shift_kind;
  logic                               round_en;
  logic                               clip_en;
  vxrm_e                              stage_vxrm;
  logic                               narrow;
  logic                               upper_half;
  logic [LANES-1:0][WORD_WIDTH-1:0]   lane_result;
  logic [LANES-1:0]                   lane_sat;

  shift_decode #(
    .VLEN (VLEN)
  ) u_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .uop_valid       (uop_valid),
    .uop_funct6      (uop_funct6),
    .uop_funct3      (uop_funct3),
    .vxrm            (vxrm),
    .vs1_data        (vs1_data),
    .vs2_data        (vs2_data),
    .rs1_data        (rs1_data),
    .uop_index       (uop_index),
    .rob_entry       (rob_entry),
    .stage_valid     (stage_valid),
    .stage_rob_entry (stage_rob_entry),
    .lane_operand    (lane_operand),
    .lane_shamt      (lane_shamt),
    .shift_kind      (shift_kind),
    .round_en        (round_en),
    .clip_en         (clip_en),
    .stage_vxrm      (stage_vxrm),
    .narrow          (narrow),
    .upper_half      (upper_half)
  );

  // one lane per 32-bit element
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    shift_lane u_lane (
      .operand     (lane_operand[i]),
      .shamt       (lane_shamt[i]),
      .shift_kind  (shift_kind),
      .round_en    (round_en),
      .clip_en     (clip_en),
      .vxrm        (stage_vxrm),
      .lane_result (lane_result[i]),
      .sat         (lane_sat[i])
    );
  end

  shift_pack #(
    .VLEN (VLEN)
  ) u_pack (
    .clk              (clk),
    .rst_n            (rst_n),
    .stage_valid      (stage_valid),
    .stage_rob_entry  (stage_rob_entry),
    .lane_result      (lane_result),
    .lane_sat         (lane_sat),
    .narrow           (narrow),
    .upper_half       (upper_half),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data),
    .result_vxsat     (result_vxsat)
  );

endmodule

// File: shift_unit_assertions.sv
`timescale 1ns/10ps

module shift_unit_assertions
  import shift_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    uop_valid,
  input funct6_e uop_funct6,
  input funct3_e uop_funct3,
  input logic    result_valid,
  input logic    result_vxsat
);

  int   fail_count = 0;
  logic accept;

  assign accept = uop_valid &&
                  (uop_funct6 inside {vsll, vsrl, vsra, vssrl, vssra,
                                      vnsrl, vnsra, vnclipu, vnclip}) &&
                  (uop_funct3 inside {opivv, opivi, opivx});

  a_reset_clear: assert property (@(posedge clk) $rose(rst_n) |-> !result_valid)
    else begin
      $error("result_valid high on the first edge out of reset");
      fail_count++;
    end

  // two register stages between accept and result
  a_latency: assert property (@(posedge clk) disable iff (!rst_n) accept |-> ##2 result_valid)
    else begin
      $error("accepted micro-op did not produce result_valid two edges later");
      fail_count++;
    end

  a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
                               result_valid |-> $past(accept, 2))
    else begin
      $error("result_valid without a recognized micro-op two edges earlier");
      fail_count++;
    end

  a_vxsat_valid: assert property (@(posedge clk) disable iff (!rst_n)
                                  result_vxsat |-> result_valid)
    else begin
      $error("result_vxsat high without result_valid");
      fail_count++;
    end

endmodule

bind shift_unit shift_unit_assertions u_assertions (.*);

// File: shift_unit_tb.sv
`timescale 1ns/10ps

module shift_unit_tb
  import shift_pkg::*;
();

  localparam int VLEN  = 128;
  localparam int LANES = VLEN / WORD_WIDTH;

  logic                       clk;
  logic                       rst_n;
  logic                       uop_valid;
  funct6_e                    uop_funct6;
  funct3_e                    uop_funct3;
  vxrm_e                      vxrm;
  logic [VLEN-1:0]            vs1_data;
  logic [VLEN-1:0]            vs2_data;
  logic [XLEN-1:0]            rs1_data;
  logic [UOP_INDEX_WIDTH-1:0] uop_index;
  logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
  logic                       result_valid;
  logic [ROB_DEPTH_WIDTH-1:0] result_rob_entry;
  logic [VLEN-1:0]            result_data;
  logic                       result_vxsat;

  logic [31:0]                lfsr_state = 32'hc63b3179;
  logic [ROB_DEPTH_WIDTH-1:0] next_rob = '0;
  logic [VLEN-1:0]            exp_data_q[$];
  logic                       exp_sat_q[$];
  logic [ROB_DEPTH_WIDTH-1:0] exp_rob_q[$];
  logic [VLEN-1:0]            exp_data;
  logic                       exp_sat;
  logic [ROB_DEPTH_WIDTH-1:0] exp_rob;
  int                         errors = 0;
  int                         checks = 0;
  int                         tests  = 0;

  shift_unit #(.VLEN(VLEN)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [VLEN-1:0] random_vec();
    logic [VLEN-1:0] v;
    for (int k = 0; k < LANES; k++) begin
      v[k*32 +: 32] = random_bits(32);
    end
    return v;
  endfunction

  // class 0 fits 16 bits, 1 above, 2 below, 3 alternates in range and above
  function automatic logic [VLEN-1:0] range_vec(input int cls, input logic uns);
    logic [VLEN-1:0] v;
    logic [31:0]     w;
    int              c;
    for (int k = 0; k < LANES; k++) begin
      w = random_bits(32);
      c = (cls == 3) ? k % 2 : cls;
      case (c)
        0: v[k*32 +: 32] = uns ? {16'd0, w[15:0]} : {{17{w[15]}}, w[14:0]};
        1: v[k*32 +: 32] = {2'b01, w[29:0]};
        default: v[k*32 +: 32] = {2'b10, w[29:0]};
      endcase
    end
    return v;
  endfunction

  function automatic funct6_e pick_op(input logic [31:0] n);
    case (n % 9)
      0: return vsll;
      1: return vsrl;
      2: return vsra;
      3: return vssrl;
      4: return vssra;
      5: return vnsrl;
      6: return vnsra;
      7: return vnclipu;
      default: return vnclip;
    endcase
  endfunction

  function automatic funct3_e pick_form(input logic [31:0] n);
    case (n % 3)
      0: return opivv;
      1: return opivx;
      default: return opivi;
    endcase
  endfunction

  // reference for one 32-bit element
  function automatic logic [31:0] lane_ref(input logic [31:0] op, input logic [4:0] sh,
                                           input funct6_e f6, input vxrm_e mode,
                                           output logic sat);
    logic signed [63:0] wide;
    logic signed [63:0] r;
    logic [31:0]        dropped;
    logic               inc;
    logic               sgn;
    logic               rounds;
    logic               clips;
    sgn     = f6 inside {vsra, vssra, vnsra, vnclip};
    rounds  = f6 inside {vssrl, vssra, vnclipu, vnclip};
    clips   = f6 inside {vnclipu, vnclip};
    sat     = 1'b0;
    wide    = sgn ? {{32{op[31]}}, op} : {32'd0, op};
    r       = wide >>> sh;
    dropped = op & ((32'd1 << sh) - 32'd1);
    inc     = 1'b0;
    if (rounds && sh != 5'd0) begin
      case (mode)
        rnu: inc = op[sh - 5'd1];
        rne: inc = op[sh - 5'd1] & (((dropped & ~(32'd1 << (sh - 5'd1))) != 0) | r[0]);
        rdn: inc = 1'b0;
        default: inc = !r[0] && (dropped != 0);
      endcase
    end
    r = r + {63'd0, inc};
    if (clips && !sgn && r > 64'sd65535) begin
      sat = 1'b1;
      r   = 64'sd65535;
    end
    if (clips && sgn && r > 64'sd32767) begin
      sat = 1'b1;
      r   = 64'sd32767;
    end
    if (clips && sgn && r < -64'sd32768) begin
      sat = 1'b1;
      r   = -64'sd32768;
    end
    if (f6 == vsll) begin
      return op << sh;
    end
    return r[31:0];
  endfunction

  task automatic build_expected(input funct6_e f6, input funct3_e f3, input vxrm_e mode,
                                input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2,
                                input logic [31:0] rs1, input logic half,
                                output logic [VLEN-1:0] data, output logic any_sat);
    logic        narrowing;
    logic [4:0]  sh;
    logic        sat;
    logic [31:0] res;
    int          base;
    narrowing = f6 inside {vnsrl, vnsra, vnclipu, vnclip};
    base      = half ? VLEN / 2 : 0;
    data      = '0;
    any_sat   = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      if (f3 != opivv) begin
        sh = rs1[4:0];
      end else if (narrowing) begin
        sh = vs1[base + i*16 +: 5];
      end else begin
        sh = vs1[i*32 +: 5];
      end
      res = lane_ref(vs2[i*32 +: 32], sh, f6, mode, sat);
      any_sat |= sat;
      if (narrowing) begin
        data[base + i*16 +: 16] = res[15:0];
      end else begin
        data[i*32 +: 32] = res;
      end
    end
  endtask

  task automatic send_uop(input funct6_e f6, input funct3_e f3, input vxrm_e mode,
                          input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2,
                          input logic [31:0] rs1, input logic [31:0] idx);
    logic [VLEN-1:0] data;
    logic            sat;
    @(posedge clk);
    #2;
    uop_valid  = 1'b1;
    uop_funct6 = f6;
    uop_funct3 = f3;
    vxrm       = mode;
    vs1_data   = vs1;
    vs2_data   = vs2;
    rs1_data   = rs1;
    uop_index  = idx[2:0];
    rob_entry  = next_rob;
    if ((f6 inside {vsll, vsrl, vsra, vssrl, vssra, vnsrl, vnsra, vnclipu, vnclip}) &&
        (f3 inside {opivv, opivi, opivx})) begin
      build_expected(f6, f3, mode, vs1, vs2, rs1, idx[0], data, sat);
      exp_data_q.push_back(data);
      exp_sat_q.push_back(sat);
      exp_rob_q.push_back(next_rob);
    end
    next_rob++;
  endtask

  function automatic int total_errors();
    return errors + DUT.u_assertions.fail_count;
  endfunction

  task automatic finish_test(input string name, input int start_errors);
    int waited;
    @(posedge clk);
    #2;
    uop_valid = 1'b0;
    waited    = 0;
    while (exp_data_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    // idle edges so a stray result still shows up in this test
    for (int n = 0; n < 4; n++) begin
      @(posedge clk);
    end
    tests++;
    if (exp_data_q.size() != 0) begin
      $display("%s timed out with %0d results missing", name, exp_data_q.size());
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      $display("%s done, %0d errors", name, total_errors() - start_errors);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("result_valid at %0t with no micro-op outstanding", $time);
        errors++;
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_sat  = exp_sat_q.pop_front();
        exp_rob  = exp_rob_q.pop_front();
        checks++;
        assert (result_data == exp_data) else begin
          $display("error at %0t: result_data expected %h, got %h", $time, exp_data,
                   result_data);
          errors++;
        end
        assert (result_vxsat == exp_sat) else begin
          $display("error at %0t: result_vxsat expected %b, got %b", $time, exp_sat,
                   result_vxsat);
          errors++;
        end
        assert (result_rob_entry == exp_rob) else begin
          $display("error at %0t: result_rob_entry expected %0d, got %0d", $time, exp_rob,
                   result_rob_entry);
          errors++;
        end
      end
    end
  end

  initial begin
    int start_err;
    uop_valid  = 1'b0;
    uop_funct6 = vsll;
    uop_funct3 = opivv;
    vxrm       = rnu;
    vs1_data   = '0;
    vs2_data   = '0;
    rs1_data   = '0;
    uop_index  = '0;
    rob_entry  = '0;
    rst_n      = 1'b1;
    #1;
    rst_n = 1'b0;
    for (int n = 0; n < 8; n++) begin
      @(posedge clk);
    end
    #2;
    rst_n = 1'b1;

    start_err = total_errors();
    for (int j = 0; j < 3; j++) begin
      for (int k = 0; k < 3; k++) begin
        send_uop(pick_op(j), pick_form(k), rnu, random_vec(), random_vec(),
                 random_bits(32), 0);
        send_uop(pick_op(j), pick_form(k), rnu, random_vec(), random_vec(),
                 random_bits(32), 0);
      end
    end
    finish_test("single-width shifts", start_err);

    start_err = total_errors();
    for (int j = 3; j < 5; j++) begin
      for (int m = 0; m < 4; m++) begin
        send_uop(pick_op(j), opivv, vxrm_e'(m[1:0]), random_vec(), random_vec(), 0, 0);
        send_uop(pick_op(j), opivx, vxrm_e'(m[1:0]), 0, random_vec(), random_bits(32), 0);
        // low five bits zero, so no rounding
        send_uop(pick_op(j), opivx, vxrm_e'(m[1:0]), 0, random_vec(), 32'h40, 0);
        // shift by one makes every odd element a tie
        send_uop(pick_op(j), opivx, vxrm_e'(m[1:0]), 0, random_vec(), 32'h21, 0);
      end
    end
    finish_test("scaling shifts", start_err);

    start_err = total_errors();
    for (int j = 5; j < 7; j++) begin
      for (int h = 0; h < 2; h++) begin
        send_uop(pick_op(j), opivv, rnu, random_vec(), random_vec(), 0, h);
        send_uop(pick_op(j), opivx, rnu, random_vec(), random_vec(), random_bits(32), h);
        send_uop(pick_op(j), opivi, rnu, random_vec(), random_vec(), random_bits(5), h);
      end
    end
    finish_test("narrowing shifts", start_err);

    start_err = total_errors();
    for (int j = 7; j < 9; j++) begin
      for (int c = 0; c < 4; c++) begin
        for (int m = 0; m < 4; m++) begin
          send_uop(pick_op(j), opivx, vxrm_e'(m[1:0]), 0, range_vec(c, j == 7),
                   random_bits(3), random_bits(1));
        end
      end
      send_uop(pick_op(j), opivv, rne, random_vec(), range_vec(0, j == 7), 0, 1);
    end
    finish_test("narrowing clips", start_err);

    start_err = total_errors();
    for (int n = 0; n < 8; n++) begin
      send_uop(pick_op(random_bits(32)), pick_form(random_bits(32)), vxrm_e'(n[1:0]),
               random_vec(), random_vec(), random_bits(32), random_bits(1));
    end
    send_uop(vsll, opivv, rnu, random_vec(), random_vec(), 0, 0);
    send_uop(funct6_e'(6'b000000), opivv, rnu, random_vec(), random_vec(), 0, 0);
    send_uop(vssra, opivx, rod, 0, random_vec(), random_bits(32), 0);
    send_uop(vsll, funct3_e'(3'b001), rnu, random_vec(), random_vec(), 0, 0);
    send_uop(vnclip, opivv, rnu, random_vec(), range_vec(3, 1'b0), 0, 1);
    finish_test("back-to-back and unrecognized", start_err);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, total_errors());
    if (total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
shift_pkg.sv
shift_decode.sv
shift_lane.sv
shift_pack.sv
shift_unit.sv
shift_unit_assertions.sv
shift_unit_tb.sv

// File: Makefile
TOP = shift_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
